// ==== compile.f ====
+incdir+rtl
rtl/router_pkg.sv
rtl/stream_if.sv
rtl/meta_fifo.sv
rtl/stream_demux.sv
rtl/user_stream_router.sv
verif/tb_user_stream_router.sv

// ==== rtl/meta_fifo.sv ====
// Register array queue with valid/ready handshake on both sides
`timescale 1ns/1ps
`default_nettype none

module meta_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             s_valid,
  output logic             s_ready,
  input  logic [WIDTH-1:0] s_data,
  output logic             m_valid,
  input  logic             m_ready,
  output logic [WIDTH-1:0] m_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Storage, no reset
  logic [WIDTH-1:0]    mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic push;
  logic pop;

  // --------------------
  // Handshake
  // --------------------
  assign s_ready = (count != CNT_BITS'(DEPTH));
  assign m_valid = (count != '0);
  // Head of queue
  assign m_data  = mem[rd_ptr];

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap explicitly, depth need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/router_defs.svh ====
// Width, depth, destination count, request field offset and opcode macros
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// --------------------
// Data path
// --------------------
`define N_DESTS        2
`define DATA_BITS      64
// Log2 of bytes per beat
`define BEAT_LOG_BITS  3

// --------------------
// Request fields
// --------------------
`define LEN_BITS       16
`define BLEN_BITS      13
`define PID_BITS       6
`define DEST_BITS      1
`define OP_BITS        2
`define REQ_BITS       25
// Resp flag on top of beat count
`define DESC_BITS      14

// Packed request layout, opcode in the low bits
`define REQ_OP_LSB     0
`define REQ_DEST_LSB   2
`define REQ_PID_LSB    3
`define REQ_LEN_LSB    9

// Queue depths
`define RQ_DEPTH       4
`define DESC_DEPTH     16

// Read response opcode
`define OPCODE_RD_RESP 2'b01

`endif

// ==== rtl/router_pkg.sv ====
// Router package with vector typedefs and demux state enum
`default_nettype none

`include "router_defs.svh"

package router_pkg;

  // --------------------
  // Stream payload
  // --------------------
  // One beat of data
  typedef logic [`DATA_BITS-1:0]   data_t;
  // One enable per byte
  typedef logic [`DATA_BITS/8-1:0] keep_t;

  // --------------------
  // Request fields
  // --------------------
  typedef logic [`PID_BITS-1:0]    pid_t;
  typedef logic [`DEST_BITS-1:0]   dest_t;
  typedef logic [`OP_BITS-1:0]     opcode_t;
  // Transfer size in bytes
  typedef logic [`LEN_BITS-1:0]    len_t;
  // Beats in transfer minus one
  typedef logic [`BLEN_BITS-1:0]   blen_t;

  // Whole request, fields at the REQ_*_LSB offsets
  typedef logic [`REQ_BITS-1:0]    req_t;
  // Resp flag above blen
  typedef logic [`DESC_BITS-1:0]   desc_t;

  // Demux FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUX_RESP,
    ST_MUX_RECV
  } demux_state_t;

endpackage

`default_nettype wire

// ==== rtl/stream_demux.sv ====
// Request driven beat demux with beat counter and descriptor generation
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module stream_demux (
  input  logic                aclk,
  input  logic                aresetn,

  // Queued request
  input  logic                rq_valid,
  output logic                rq_ready,
  input  router_pkg::req_t    rq_data,

  // Forwarded request
  output logic                fwd_valid,
  input  logic                fwd_ready,
  output router_pkg::req_t    fwd_data,

  // Per destination descriptor
  output logic [`N_DESTS-1:0] desc_valid,
  input  logic [`N_DESTS-1:0] desc_ready,
  output router_pkg::desc_t   desc_data,

  // Streams
  stream_if.dst               s_axis,
  stream_if.src               m_resp [`N_DESTS],
  stream_if.src               m_recv [`N_DESTS]
);
  import router_pkg::*;

  // FSM and held transfer context
  demux_state_t state_r;
  demux_state_t state_nxt;
  dest_t        dest_r;
  dest_t        dest_nxt;
  pid_t         pid_r;
  pid_t         pid_nxt;
  // Beats left minus one
  blen_t        cnt_r;
  blen_t        cnt_nxt;

  // Decoded request
  opcode_t      req_op;
  dest_t        req_dest;
  pid_t         req_pid;
  len_t         req_len;
  len_t         req_len_m1;
  blen_t        req_blen;
  logic         req_resp;

  // Sink readies gathered per lane
  logic [`N_DESTS-1:0] resp_ready;
  logic [`N_DESTS-1:0] recv_ready;
  logic                in_ready;

  logic beat;
  logic tr_done;
  logic can_take;
  logic take;

  // --------------------
  // Request decode
  // --------------------
  assign req_op   = rq_data[`REQ_OP_LSB +: `OP_BITS];
  assign req_dest = rq_data[`REQ_DEST_LSB +: `DEST_BITS];
  assign req_pid  = rq_data[`REQ_PID_LSB +: `PID_BITS];
  assign req_len  = rq_data[`REQ_LEN_LSB +: `LEN_BITS];

  // Read responses to resp and all else to recv
  assign req_resp = (req_op == `OPCODE_RD_RESP);

  // Zero based index of last beat
  assign req_len_m1 = req_len - len_t'(1);
  assign req_blen   = blen_t'(req_len_m1 >> `BEAT_LOG_BITS);

  // --------------------
  // Acceptance
  // --------------------
  assign beat    = s_axis.valid & in_ready;
  // Handshake on the last counted beat
  assign tr_done = (state_r != ST_IDLE) && (cnt_r == '0) && beat;

  // Both output queues must have room
  assign can_take = rq_valid && fwd_ready && desc_ready[req_dest];
  // Take when idle or back to back on the last beat
  assign take     = can_take && ((state_r == ST_IDLE) || tr_done);

  assign rq_ready  = take;
  assign fwd_valid = take;
  assign fwd_data  = rq_data;
  assign desc_data = {req_resp, req_blen};

  // Descriptor push only on the request's lane
  for (genvar i = 0; i < `N_DESTS; i++) begin : g_desc
    assign desc_valid[i] = take && (req_dest == dest_t'(i));
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_nxt = state_r;
    dest_nxt  = dest_r;
    pid_nxt   = pid_r;
    cnt_nxt   = cnt_r;

    if (take) begin
      // Load new context
      state_nxt = req_resp ? ST_MUX_RESP : ST_MUX_RECV;
      dest_nxt  = req_dest;
      pid_nxt   = req_pid;
      cnt_nxt   = req_blen;
    end else if (tr_done) begin
      // Transfer done with nothing taken
      state_nxt = ST_IDLE;
    end else if (beat) begin
      cnt_nxt = cnt_r - blen_t'(1);
    end
  end

  // Control registers
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_r <= ST_IDLE;
      dest_r  <= '0;
      cnt_r   <= '0;
    end else begin
      state_r <= state_nxt;
      dest_r  <= dest_nxt;
      cnt_r   <= cnt_nxt;
    end
  end

  // Pid tag for outgoing beats
  always_ff @(posedge aclk) begin
    pid_r <= pid_nxt;
  end

  // --------------------
  // Beat steering
  // --------------------
  for (genvar i = 0; i < `N_DESTS; i++) begin : g_lane
    // Resp lane
    assign m_resp[i].valid = s_axis.valid && (state_r == ST_MUX_RESP) &&
                             (dest_r == dest_t'(i));
    assign m_resp[i].data  = s_axis.data;
    assign m_resp[i].keep  = s_axis.keep;
    assign m_resp[i].last  = s_axis.last;
    assign m_resp[i].id    = pid_r;
    assign resp_ready[i]   = m_resp[i].ready;

    // Recv lane
    assign m_recv[i].valid = s_axis.valid && (state_r == ST_MUX_RECV) &&
                             (dest_r == dest_t'(i));
    assign m_recv[i].data  = s_axis.data;
    assign m_recv[i].keep  = s_axis.keep;
    assign m_recv[i].last  = s_axis.last;
    assign m_recv[i].id    = pid_r;
    assign recv_ready[i]   = m_recv[i].ready;
  end

  // Input ready follows the selected sink
  always_comb begin
    case (state_r)
      ST_MUX_RESP: in_ready = resp_ready[dest_r];
      ST_MUX_RECV: in_ready = recv_ready[dest_r];
      default:     in_ready = 1'b0;
    endcase
  end

  assign s_axis.ready = in_ready;

endmodule

`default_nettype wire

// ==== rtl/stream_if.sv ====
// Data stream interface with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface stream_if;
  import router_pkg::*;

  // Handshake
  logic  valid;
  logic  ready;

  // Payload
  data_t data;
  keep_t keep;
  logic  last;
  // Tagged with the request pid
  pid_t  id;

  // Driving side
  modport src (
    output valid, data, keep, last, id,
    input  ready
  );

  // Receiving side
  modport dst (
    input  valid, data, keep, last, id,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/user_stream_router.sv ====
// Write stream router top level with request, descriptor and stream ports
`timescale 1ns/1ps
`default_nettype none

`include "router_defs.svh"

module user_stream_router (
  input  logic                                 aclk,
  input  logic                                 aresetn,

  // Incoming request
  input  logic                                 s_rq_valid,
  output logic                                 s_rq_ready,
  input  router_pkg::opcode_t                  s_rq_opcode,
  input  router_pkg::dest_t                    s_rq_dest,
  input  router_pkg::pid_t                     s_rq_pid,
  input  router_pkg::len_t                     s_rq_len,

  // Incoming data
  input  logic                                 s_axis_tvalid,
  output logic                                 s_axis_tready,
  input  router_pkg::data_t                    s_axis_tdata,
  input  router_pkg::keep_t                    s_axis_tkeep,
  input  logic                                 s_axis_tlast,

  // Forwarded request
  output logic                                 m_rq_valid,
  input  logic                                 m_rq_ready,
  output router_pkg::opcode_t                  m_rq_opcode,
  output router_pkg::dest_t                    m_rq_dest,
  output router_pkg::pid_t                     m_rq_pid,
  output router_pkg::len_t                     m_rq_len,

  // Descriptors
  output logic [`N_DESTS-1:0]                  m_mux_valid,
  input  logic [`N_DESTS-1:0]                  m_mux_ready,
  output router_pkg::desc_t [`N_DESTS-1:0]     m_mux_data,

  // Resp streams
  output logic [`N_DESTS-1:0]                  m_axis_resp_tvalid,
  input  logic [`N_DESTS-1:0]                  m_axis_resp_tready,
  output router_pkg::data_t [`N_DESTS-1:0]     m_axis_resp_tdata,
  output router_pkg::keep_t [`N_DESTS-1:0]     m_axis_resp_tkeep,
  output logic [`N_DESTS-1:0]                  m_axis_resp_tlast,
  output router_pkg::pid_t [`N_DESTS-1:0]      m_axis_resp_tid,

  // Recv streams
  output logic [`N_DESTS-1:0]                  m_axis_recv_tvalid,
  input  logic [`N_DESTS-1:0]                  m_axis_recv_tready,
  output router_pkg::data_t [`N_DESTS-1:0]     m_axis_recv_tdata,
  output router_pkg::keep_t [`N_DESTS-1:0]     m_axis_recv_tkeep,
  output logic [`N_DESTS-1:0]                  m_axis_recv_tlast,
  output router_pkg::pid_t [`N_DESTS-1:0]      m_axis_recv_tid
);
  import router_pkg::*;

  // Packed request at input
  req_t                s_rq_data;

  // Request queue to demux
  logic                rq_q_valid;
  logic                rq_q_ready;
  req_t                rq_q_data;

  // Demux to forwarded request queue
  logic                fwd_valid;
  logic                fwd_ready;
  req_t                fwd_data;
  req_t                m_rq_data;

  // Demux to descriptor queues, data shared by all lanes
  logic [`N_DESTS-1:0] desc_valid;
  logic [`N_DESTS-1:0] desc_ready;
  desc_t               desc_data;

  stream_if s_axis_if ();
  stream_if resp_if [`N_DESTS] ();
  stream_if recv_if [`N_DESTS] ();

  // --------------------
  // Request pack/unpack
  // --------------------
  always_comb begin
    s_rq_data = '0;
    s_rq_data[`REQ_OP_LSB +: `OP_BITS]     = s_rq_opcode;
    s_rq_data[`REQ_DEST_LSB +: `DEST_BITS] = s_rq_dest;
    s_rq_data[`REQ_PID_LSB +: `PID_BITS]   = s_rq_pid;
    s_rq_data[`REQ_LEN_LSB +: `LEN_BITS]   = s_rq_len;
  end

  assign m_rq_opcode = m_rq_data[`REQ_OP_LSB +: `OP_BITS];
  assign m_rq_dest   = m_rq_data[`REQ_DEST_LSB +: `DEST_BITS];
  assign m_rq_pid    = m_rq_data[`REQ_PID_LSB +: `PID_BITS];
  assign m_rq_len    = m_rq_data[`REQ_LEN_LSB +: `LEN_BITS];

  // --------------------
  // Stream flattening
  // --------------------
  assign s_axis_if.valid = s_axis_tvalid;
  assign s_axis_if.data  = s_axis_tdata;
  assign s_axis_if.keep  = s_axis_tkeep;
  assign s_axis_if.last  = s_axis_tlast;
  // Input stream has no id
  assign s_axis_if.id    = '0;
  assign s_axis_tready   = s_axis_if.ready;

  for (genvar i = 0; i < `N_DESTS; i++) begin : g_flat
    assign m_axis_resp_tvalid[i] = resp_if[i].valid;
    assign m_axis_resp_tdata[i]  = resp_if[i].data;
    assign m_axis_resp_tkeep[i]  = resp_if[i].keep;
    assign m_axis_resp_tlast[i]  = resp_if[i].last;
    assign m_axis_resp_tid[i]    = resp_if[i].id;
    assign resp_if[i].ready      = m_axis_resp_tready[i];

    assign m_axis_recv_tvalid[i] = recv_if[i].valid;
    assign m_axis_recv_tdata[i]  = recv_if[i].data;
    assign m_axis_recv_tkeep[i]  = recv_if[i].keep;
    assign m_axis_recv_tlast[i]  = recv_if[i].last;
    assign m_axis_recv_tid[i]    = recv_if[i].id;
    assign recv_if[i].ready      = m_axis_recv_tready[i];
  end

  // --------------------
  // Pipeline
  // --------------------
  // Input request queue
  meta_fifo #(.WIDTH(`REQ_BITS), .DEPTH(`RQ_DEPTH)) rq_fifo_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_rq_valid),
    .s_ready (s_rq_ready),
    .s_data  (s_rq_data),
    .m_valid (rq_q_valid),
    .m_ready (rq_q_ready),
    .m_data  (rq_q_data)
  );

  stream_demux stream_demux_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .rq_valid   (rq_q_valid),
    .rq_ready   (rq_q_ready),
    .rq_data    (rq_q_data),
    .fwd_valid  (fwd_valid),
    .fwd_ready  (fwd_ready),
    .fwd_data   (fwd_data),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc_data  (desc_data),
    .s_axis     (s_axis_if),
    .m_resp     (resp_if),
    .m_recv     (recv_if)
  );

  // Forwarded request queue
  meta_fifo #(.WIDTH(`REQ_BITS), .DEPTH(`RQ_DEPTH)) fwd_fifo_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (fwd_valid),
    .s_ready (fwd_ready),
    .s_data  (fwd_data),
    .m_valid (m_rq_valid),
    .m_ready (m_rq_ready),
    .m_data  (m_rq_data)
  );

  // One descriptor queue per destination
  for (genvar i = 0; i < `N_DESTS; i++) begin : g_desc_q
    meta_fifo #(.WIDTH(`DESC_BITS), .DEPTH(`DESC_DEPTH)) desc_fifo_i (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (desc_valid[i]),
      .s_ready (desc_ready[i]),
      .s_data  (desc_data),
      .m_valid (m_mux_valid[i]),
      .m_ready (m_mux_ready[i]),
      .m_data  (m_mux_data[i])
    );
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator

verilator --binary --timing -f compile.f --top-module tb_user_stream_router \
  -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation error"; exit 1; }

cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== verif/tb_user_stream_router.sv ====
// Directed testbench for the router with clock, reset, LCG, scoreboards and tests
`timescale 1ns/1ps
`default_nettype none

module tb_user_stream_router;

  localparam int TMO = 2000;

  // Packed beat {last, id, keep, data}
  typedef logic [78:0] beat_t;

  logic aclk = 1'b0;
  logic aresetn;

  logic        s_rq_valid;
  logic        s_rq_ready;
  logic [1:0]  s_rq_opcode;
  logic        s_rq_dest;
  logic [5:0]  s_rq_pid;
  logic [15:0] s_rq_len;

  logic        s_axis_tvalid;
  logic        s_axis_tready;
  logic [63:0] s_axis_tdata;
  logic [7:0]  s_axis_tkeep;
  logic        s_axis_tlast;

  logic        m_rq_valid;
  logic        m_rq_ready = 1'b1;
  logic [1:0]  m_rq_opcode;
  logic        m_rq_dest;
  logic [5:0]  m_rq_pid;
  logic [15:0] m_rq_len;

  logic [1:0]        m_mux_valid;
  logic [1:0]        m_mux_ready = '1;
  logic [1:0][13:0]  m_mux_data;

  logic [1:0]        resp_valid;
  logic [1:0]        resp_ready = '1;
  logic [1:0][63:0]  resp_data;
  logic [1:0][7:0]   resp_keep;
  logic [1:0]        resp_last;
  logic [1:0][5:0]   resp_id;

  logic [1:0]        recv_valid;
  logic [1:0]        recv_ready = '1;
  logic [1:0][63:0]  recv_data;
  logic [1:0][7:0]   recv_keep;
  logic [1:0]        recv_last;
  logic [1:0][5:0]   recv_id;

  // Scoreboard state
  beat_t       exp_resp [2][$];
  beat_t       exp_recv [2][$];
  logic [13:0] exp_desc [2][$];
  logic [24:0] exp_rq [$];
  // Stimulus still to drive
  logic [24:0] pend_rq [$];
  beat_t       pend_beat [$];

  // Observed traffic for directed checks
  int          resp_seen [2] = '{0, 0};
  logic [13:0] last_desc [2];

  logic [31:0] lcg_state = 32'h49de4472;
  // Separate stream for the sink readies
  logic [31:0] ready_state = 32'h49de4472;
  logic        rand_ready = 1'b0;
  logic        rq_hold = 1'b0;
  int          errors = 0;
  int          tests = 0;
  string       test_name = "reset";

  user_stream_router user_stream_router_i (
    .aclk (aclk), .aresetn (aresetn),
    .s_rq_valid (s_rq_valid), .s_rq_ready (s_rq_ready), .s_rq_opcode (s_rq_opcode),
    .s_rq_dest (s_rq_dest), .s_rq_pid (s_rq_pid), .s_rq_len (s_rq_len),
    .s_axis_tvalid (s_axis_tvalid), .s_axis_tready (s_axis_tready),
    .s_axis_tdata (s_axis_tdata), .s_axis_tkeep (s_axis_tkeep), .s_axis_tlast (s_axis_tlast),
    .m_rq_valid (m_rq_valid), .m_rq_ready (m_rq_ready), .m_rq_opcode (m_rq_opcode),
    .m_rq_dest (m_rq_dest), .m_rq_pid (m_rq_pid), .m_rq_len (m_rq_len),
    .m_mux_valid (m_mux_valid), .m_mux_ready (m_mux_ready), .m_mux_data (m_mux_data),
    .m_axis_resp_tvalid (resp_valid), .m_axis_resp_tready (resp_ready),
    .m_axis_resp_tdata (resp_data), .m_axis_resp_tkeep (resp_keep),
    .m_axis_resp_tlast (resp_last), .m_axis_resp_tid (resp_id),
    .m_axis_recv_tvalid (recv_valid), .m_axis_recv_tready (recv_ready),
    .m_axis_recv_tdata (recv_data), .m_axis_recv_tkeep (recv_keep),
    .m_axis_recv_tlast (recv_last), .m_axis_recv_tid (recv_id)
  );

  // 100 ns clock
  always #50 aclk = ~aclk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // --------------------
  // Sink models
  // --------------------
  // Random or open readies with optional forwarded request hold
  always @(posedge aclk) begin
    logic [31:0] r;
    ready_state = lcg_step(ready_state);
    r = ready_state;
    resp_ready  <= rand_ready ? r[1:0] | r[9:8] : 2'b11;
    recv_ready  <= rand_ready ? r[3:2] | r[11:10] : 2'b11;
    m_mux_ready <= rand_ready ? r[5:4] : 2'b11;
    m_rq_ready  <= rq_hold ? 1'b0 : (rand_ready ? r[6] : 1'b1);
  end

  // Compare every handshake against the expected queues
  always @(posedge aclk) begin
    if (aresetn) begin
      for (int i = 0; i < 2; i++) begin
        if (resp_valid[i] && resp_ready[i]) begin
          resp_seen[i]++;
          if (exp_resp[i].size() == 0) begin
            $display("Unexpected beat on resp lane %0d in %s", i, test_name);
            errors++;
          end else begin
            check($sformatf("resp%0d beat", i), exp_resp[i].pop_front(),
                  {resp_last[i], resp_id[i], resp_keep[i], resp_data[i]});
          end
        end
        if (recv_valid[i] && recv_ready[i]) begin
          if (exp_recv[i].size() == 0) begin
            $display("Unexpected beat on recv lane %0d in %s", i, test_name);
            errors++;
          end else begin
            check($sformatf("recv%0d beat", i), exp_recv[i].pop_front(),
                  {recv_last[i], recv_id[i], recv_keep[i], recv_data[i]});
          end
        end
        if (m_mux_valid[i] && m_mux_ready[i]) begin
          last_desc[i] = m_mux_data[i];
          if (exp_desc[i].size() == 0) begin
            $display("Unexpected descriptor on lane %0d in %s", i, test_name);
            errors++;
          end else begin
            check($sformatf("desc%0d", i), exp_desc[i].pop_front(), m_mux_data[i]);
          end
        end
      end
      if (m_rq_valid && m_rq_ready) begin
        if (exp_rq.size() == 0) begin
          $display("Unexpected forwarded request in %s", test_name);
          errors++;
        end else begin
          check("m_rq", exp_rq.pop_front(), {m_rq_len, m_rq_pid, m_rq_dest, m_rq_opcode});
        end
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  // Queue a request with its beats and expected results
  task automatic add_request(input logic [1:0] op, input logic dest,
                             input logic [5:0] pid, input logic [15:0] len);
    int    nbeats;
    beat_t b;
    logic  resp;
    nbeats = ((len - 16'd1) >> 3) + 1;
    resp = (op == 2'b01);
    pend_rq.push_back({len, pid, dest, op});
    exp_rq.push_back({len, pid, dest, op});
    exp_desc[dest].push_back({resp, 13'(nbeats - 1)});
    for (int k = 0; k < nbeats; k++) begin
      b = '0;
      b[63:0]  = {lcg_next(), lcg_next()};
      b[71:64] = 8'(lcg_next());
      b[78]    = (k == nbeats - 1);
      pend_beat.push_back(b);
      b[77:72] = pid;
      if (resp) begin
        exp_resp[dest].push_back(b);
      end else begin
        exp_recv[dest].push_back(b);
      end
    end
  endtask

  task automatic drive_requests();
    logic [24:0] r;
    int          t;
    while (pend_rq.size() > 0) begin
      r = pend_rq.pop_front();
      s_rq_valid  <= 1'b1;
      {s_rq_len, s_rq_pid, s_rq_dest, s_rq_opcode} <= r;
      t = 0;
      do begin
        @(posedge aclk);
        t++;
      end while (!s_rq_ready && t < TMO);
      if (t >= TMO) begin
        $display("Timeout waiting for s_rq_ready in %s", test_name);
        errors++;
        pend_rq.delete();
      end
    end
    s_rq_valid <= 1'b0;
  endtask

  task automatic drive_beats();
    beat_t b;
    int    t;
    while (pend_beat.size() > 0) begin
      b = pend_beat.pop_front();
      s_axis_tvalid <= 1'b1;
      {s_axis_tlast, s_axis_tkeep, s_axis_tdata} <= {b[78], b[71:0]};
      t = 0;
      do begin
        @(posedge aclk);
        t++;
      end while (!s_axis_tready && t < TMO);
      if (t >= TMO) begin
        $display("Timeout waiting for s_axis_tready in %s", test_name);
        errors++;
        pend_beat.delete();
      end
    end
    s_axis_tvalid <= 1'b0;
  endtask

  // Wait until every expected item has been seen
  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_rq.size() + exp_desc[0].size() + exp_desc[1].size() + exp_resp[0].size() +
            exp_resp[1].size() + exp_recv[0].size() + exp_recv[1].size()) != 0 && t < TMO) begin
      @(posedge aclk);
      t++;
    end
    if (t >= TMO) begin
      $display("Timeout, outputs not delivered in %s", test_name);
      errors++;
    end
  endtask

  task automatic run_traffic();
    fork
      drive_requests();
      drive_beats();
    join
    wait_drain();
  endtask

  task automatic report(input int start_errors);
    tests++;
    $display("[DONE] %s errors=%0d", test_name, errors - start_errors);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic idle_after_reset();
    int e0;
    e0 = errors;
    test_name = "reset_idle";
    check("s_axis_tready", 0, s_axis_tready);
    check("resp_valid", 0, resp_valid);
    check("recv_valid", 0, recv_valid);
    check("m_rq_valid", 0, m_rq_valid);
    check("m_mux_valid", 0, m_mux_valid);
    report(e0);
  endtask

  task automatic resp_to_dest0();
    int e0;
    int s0;
    e0 = errors;
    s0 = resp_seen[0];
    test_name = "resp_dest0";
    add_request(2'b01, 1'b0, 6'h15, 16'd24);
    run_traffic();
    // Three beats and descriptor {1, 2}
    check("beat count", 3, resp_seen[0] - s0);
    check("desc", {1'b1, 13'd2}, last_desc[0]);
    report(e0);
  endtask

  task automatic recv_to_dest1();
    int e0;
    e0 = errors;
    test_name = "recv_dest1";
    add_request(2'b10, 1'b1, 6'h2a, 16'd17);
    run_traffic();
    report(e0);
  endtask

  task automatic random_burst();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    test_name = "random_burst";
    rand_ready = 1'b1;
    for (int n = 0; n < 20; n++) begin
      r = lcg_next();
      add_request(r[1:0], r[2], r[8:3], 16'(r[21:16] + 1));
    end
    run_traffic();
    rand_ready = 1'b0;
    report(e0);
  endtask

  task automatic request_backpressure();
    int   e0;
    int   t;
    logic saw_full;
    e0 = errors;
    test_name = "backpressure";
    saw_full = 1'b0;
    rq_hold = 1'b1;
    for (int n = 0; n < 10; n++) begin
      add_request(2'(n), 1'(n), 6'(n + 3), 16'd8);
    end
    fork
      drive_requests();
      drive_beats();
      begin
        t = 0;
        while (!(s_rq_valid && !s_rq_ready) && t < TMO) begin
          @(posedge aclk);
          t++;
        end
        saw_full = (t < TMO);
        repeat (5) @(posedge aclk);
        rq_hold = 1'b0;
      end
    join
    check("s_rq_ready low when full", 1, saw_full);
    wait_drain();
    report(e0);
  endtask

  initial begin
    aresetn       <= 1'b0;
    s_rq_valid    <= 1'b0;
    s_rq_opcode   <= '0;
    s_rq_dest     <= '0;
    s_rq_pid      <= '0;
    s_rq_len      <= '0;
    s_axis_tvalid <= 1'b0;
    s_axis_tdata  <= '0;
    s_axis_tkeep  <= '0;
    s_axis_tlast  <= 1'b0;
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (2) @(posedge aclk);

    idle_after_reset();
    resp_to_dest0();
    recv_to_dest1();
    random_burst();
    request_backpressure();

    repeat (4) @(posedge aclk);
    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
